/* include/status_consts.svh */
//////////////////////////////////////////////////
// status bus constants, shared by queue and clients
// queue depth must be 2 or more; wait cycles 1 or more
//////////////////////////////////////////////////

`ifndef STATUS_CONSTS_SVH
`define STATUS_CONSTS_SVH

// command queue entries == host credits after reset
`define STATUS_CMD_DEPTH 4

// data path width of the register bus
`define STATUS_DATA_W 32

//////////////////////////////////////////////////
// address windows
//////////////////////////////////////////////////

`define OPTICS_PAGE 8'h04 // flat view page, 0x400-0x4ff
`define RECO_WINDOW 9'b0000_0110_0 // window view, 0x600-0x67f

// optics register offsets inside the page
`define OPTICS_REG_CTRL 8'd0 // r/w control pins
`define OPTICS_REG_ALARM 8'd1 // sticky, write one to clear
`define OPTICS_REG_PINS 8'd2 // live alarm inputs

// waitrequest cycles per reconfig access
`define RECO_WAIT_CYCLES 3

`endif

/* hdl/status_bus_pkg.sv */
//////////////////////////////////////////////////
// status bus word address, decoded two ways
//////////////////////////////////////////////////

package status_bus_pkg;

	// page / offset split, used by optics
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} status_flat_t;

	// 128-word window split, used by reco
	typedef struct packed {
		logic [8:0] window;
		logic [6:0] offset;
	} status_win_t;

	// same 16 bits, pick the view by client
	typedef union packed {
		logic [15:0]  word;
		status_flat_t flat;
		status_win_t  win;
	} status_addr_t;

endpackage

/* hdl/status_cmd_queue.sv */
//////////////////////////////////////////////////
// credit based command FIFO, no ready toward host
// host must hold cmd_valid low without a credit
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module status_cmd_queue (
	input  logic                         clk_status,
	input  logic                         arst,
	input  logic                         cmd_valid,
	input  logic                         cmd_write,
	input  status_bus_pkg::status_addr_t cmd_addr,
	input  logic [`STATUS_DATA_W-1:0]    cmd_writedata,
	input  logic                         reco_wait,
	output logic                         cmd_credit,   // one pulse per pop
	output logic                         st_read,
	output logic                         st_write,
	output status_bus_pkg::status_addr_t st_addr,
	output logic [`STATUS_DATA_W-1:0]    st_writedata
);
	import status_bus_pkg::*;

	localparam int DEPTH = `STATUS_CMD_DEPTH;
	localparam int DW    = `STATUS_DATA_W;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic         q_write [DEPTH];
	status_addr_t q_addr  [DEPTH];
	logic [DW-1:0] q_data [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic          head_write;
	status_addr_t  head_addr;
	logic [DW-1:0] head_data;
	logic          have_cmd;
	logic          reco_in_stage;
	logic          stall;
	logic          pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // circular wrap
	endfunction

	//////////////////////////////////////////////////
	// head select, empty queue passes input straight
	//////////////////////////////////////////////////

	always_comb begin
		if (count == '0) begin
			head_write = cmd_write;
			head_addr  = cmd_addr;
			head_data  = cmd_writedata;
		end else begin
			head_write = q_write[rd_ptr];
			head_addr  = q_addr[rd_ptr];
			head_data  = q_data[rd_ptr];
		end
	end

	assign have_cmd = cmd_valid || (count != '0);

	// reco raises wait only a cycle after its strobe,
	// so hold off the pop while that strobe is in the stage
	assign reco_in_stage = (st_read || st_write) && (st_addr.win.window == `RECO_WINDOW);
	assign stall         = reco_wait || reco_in_stage;
	assign pop           = have_cmd && !stall;

	// storage, written even when bypassed
	always_ff @(posedge clk_status) begin
		if (cmd_valid) begin
			q_write[wr_ptr] <= cmd_write;
			q_addr[wr_ptr]  <= cmd_addr;
			q_data[wr_ptr]  <= cmd_writedata;
		end
	end

	//////////////////////////////////////////////////
	// pointers, count, registered command stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (arst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			cmd_credit <= 1'b0;
			st_read    <= 1'b0;
			st_write   <= 1'b0;
		end else begin
			if (cmd_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			count      <= count + CNT_W'(cmd_valid) - CNT_W'(pop); // never over DEPTH
			cmd_credit <= pop;                // credit back on the pop edge
			st_read    <= pop && !head_write; // strobes last one cycle
			st_write   <= pop && head_write;
		end
	end

	// payload holds between pops
	always_ff @(posedge clk_status) begin
		if (pop) begin
			st_addr      <= head_addr;
			st_writedata <= head_data;
		end
	end

endmodule

/* hdl/optics_control.sv */
//////////////////////////////////////////////////
// CFP control pins and alarm latch on the flat page
// alarm inputs are taken as already synchronous
// cfp_mod_rst is active low, reset holds module in reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module optics_control (
	input  logic                         clk_status,
	input  logic                         arst,
	input  logic                         st_read,
	input  logic                         st_write,
	input  status_bus_pkg::status_addr_t st_addr,
	input  logic [`STATUS_DATA_W-1:0]    st_writedata,
	output logic [`STATUS_DATA_W-1:0]    readdata,
	output logic                         readdata_valid,

	// CFP control outputs
	output logic                         cfp_mod_lopwr,
	output logic                         cfp_mod_rst,  // active low
	output logic                         cfp_tx_dis,
	output logic [3:1]                   cfp_prg_cntl,

	// CFP alarm inputs
	input  logic                         cfp_glb_alrm,
	input  logic                         cfp_mod_abs,
	input  logic                         cfp_rx_los,
	input  logic [3:1]                   cfp_prg_alrm
);

	localparam int DW    = `STATUS_DATA_W;
	localparam int CTL_W = 6; // lopwr, rst, tx_dis, prg_cntl[3:1]
	localparam int ALM_W = 6; // glb, abs, los, prg_alrm[3:1]

	logic [CTL_W-1:0] ctrl;
	logic [ALM_W-1:0] alarm;     // sticky copy of pins
	logic [ALM_W-1:0] pins;      // live levels
	logic [ALM_W-1:0] alarm_clr;
	logic             hit;
	logic             ctrl_wr;
	logic             alarm_wr;

	assign pins = {cfp_prg_alrm, cfp_rx_los, cfp_mod_abs, cfp_glb_alrm};

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	assign hit      = (st_addr.flat.page == `OPTICS_PAGE);
	assign ctrl_wr  = st_write && hit && (st_addr.flat.offset == `OPTICS_REG_CTRL);
	assign alarm_wr = st_write && hit && (st_addr.flat.offset == `OPTICS_REG_ALARM);

	// only bits written as one get cleared
	assign alarm_clr = alarm_wr ? st_writedata[ALM_W-1:0] : '0;

	always_ff @(posedge clk_status) begin
		if (arst) begin
			ctrl           <= '0; // mod_rst low, module held in reset
			alarm          <= '0;
			readdata_valid <= 1'b0;
		end else begin
			if (ctrl_wr)
				ctrl <= st_writedata[CTL_W-1:0];
			alarm          <= (alarm & ~alarm_clr) | pins; // a set on the same edge wins
			readdata_valid <= st_read && hit; // fixed one cycle answer
		end
	end

	// read mux, alarm shows value before this edge
	always_ff @(posedge clk_status) begin
		if (st_read && hit) begin
			case (st_addr.flat.offset)
				`OPTICS_REG_CTRL:  readdata <= DW'(ctrl);
				`OPTICS_REG_ALARM: readdata <= DW'(alarm);
				`OPTICS_REG_PINS:  readdata <= DW'(pins);
				default:           readdata <= '0; // unmapped, host never asks
			endcase
		end
	end

	//////////////////////////////////////////////////
	// pins from ctrl bits
	//////////////////////////////////////////////////

	assign cfp_mod_lopwr = ctrl[0];
	assign cfp_mod_rst   = ctrl[1];
	assign cfp_tx_dis    = ctrl[2];
	assign cfp_prg_cntl  = ctrl[5:3];

endmodule

/* hdl/reco_window.sv */
//////////////////////////////////////////////////
// transceiver reconfig window, 128 words at 0x600
// every access waits RECO_WAIT_CYCLES; regs have no reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module reco_window (
	input  logic                         clk_status,
	input  logic                         arst,
	input  logic                         st_read,
	input  logic                         st_write,
	input  status_bus_pkg::status_addr_t st_addr,
	input  logic [`STATUS_DATA_W-1:0]    st_writedata,
	output logic [`STATUS_DATA_W-1:0]    readdata,
	output logic                         readdata_valid,
	output logic                         reco_wait      // stalls the command stage
);

	localparam int DW    = `STATUS_DATA_W;
	localparam int CNT_W = $clog2(`RECO_WAIT_CYCLES + 1);

	logic [DW-1:0]    regs [128];
	logic             hit;
	logic             done;      // last wait cycle
	logic             pend_read;
	logic             pend_write;
	logic [6:0]       pend_off;
	logic [DW-1:0]    pend_data;
	logic [CNT_W-1:0] wait_cnt;

	assign hit  = (st_read || st_write) && (st_addr.win.window == `RECO_WINDOW);
	assign done = reco_wait && (wait_cnt == '0);

	//////////////////////////////////////////////////
	// wait sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (arst) begin
			reco_wait      <= 1'b0;
			wait_cnt       <= '0;
			pend_read      <= 1'b0;
			pend_write     <= 1'b0;
			readdata_valid <= 1'b0;
		end else begin
			readdata_valid <= done && pend_read; // same edge wait drops
			if (hit) begin
				reco_wait  <= 1'b1;
				wait_cnt   <= CNT_W'(`RECO_WAIT_CYCLES - 1);
				pend_read  <= st_read;
				pend_write <= st_write;
			end else if (done) begin
				reco_wait  <= 1'b0;
				pend_read  <= 1'b0;
				pend_write <= 1'b0;
			end else if (reco_wait) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	// capture access, then hit the file at the end
	always_ff @(posedge clk_status) begin
		if (hit) begin
			pend_off  <= st_addr.win.offset;
			pend_data <= st_writedata;
		end
		if (done && pend_write)
			regs[pend_off] <= pend_data;
		if (done)
			readdata <= regs[pend_off]; // old word on a write, unused
	end

endmodule

/* hdl/status_read_combine.sv */
//////////////////////////////////////////////////
// merges client read returns into one host response
// clients must never answer in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module status_read_combine #(
	parameter int NUM_CLIENTS = 2
) (
	input  logic                                  clk_status,
	input  logic                                  arst,
	input  logic [NUM_CLIENTS-1:0]                client_valid,
	input  logic [NUM_CLIENTS*`STATUS_DATA_W-1:0] client_data,  // client 0 in low word
	output logic                                  rsp_valid,
	output logic [`STATUS_DATA_W-1:0]             rsp_data
);

	localparam int DW = `STATUS_DATA_W;

	logic [DW-1:0] sel_data;

	// and-or mux, one hot valids
	always_comb begin
		sel_data = '0;
		for (int i = 0; i < NUM_CLIENTS; i++) begin
			if (client_valid[i])
				sel_data = sel_data | client_data[i*DW +: DW];
		end
	end

	always_ff @(posedge clk_status) begin
		if (arst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= |client_valid;
	end

	always_ff @(posedge clk_status) begin
		if (|client_valid)
			rsp_data <= sel_data; // held until next response
	end

endmodule

/* hdl/status_subsystem.sv */
//////////////////////////////////////////////////
// status bus top: command queue, optics, reco window
// host keeps STATUS_CMD_DEPTH credits; unmapped reads hang
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module status_subsystem (
	input  logic                         clk_status,
	input  logic                         arst,

	// host command side
	input  logic                         cmd_valid,
	input  logic                         cmd_write,
	input  status_bus_pkg::status_addr_t cmd_addr,
	input  logic [`STATUS_DATA_W-1:0]    cmd_writedata,
	output logic                         cmd_credit,
	output logic                         rsp_valid,
	output logic [`STATUS_DATA_W-1:0]    rsp_data,

	// CFP pins
	output logic                         cfp_mod_lopwr,
	output logic                         cfp_mod_rst,    // active low
	output logic                         cfp_tx_dis,
	output logic [3:1]                   cfp_prg_cntl,
	input  logic                         cfp_glb_alrm,
	input  logic                         cfp_mod_abs,
	input  logic                         cfp_rx_los,
	input  logic [3:1]                   cfp_prg_alrm
);
	import status_bus_pkg::*;

	// registered command stage
	logic                      st_read;
	logic                      st_write;
	status_addr_t              st_addr;
	logic [`STATUS_DATA_W-1:0] st_writedata;

	// client returns
	logic                      reco_wait;
	logic [`STATUS_DATA_W-1:0] cfp_readdata;
	logic                      cfp_readdata_valid;
	logic [`STATUS_DATA_W-1:0] reco_readdata;
	logic                      reco_readdata_valid;

	//////////////////////////////////////////////////
	// command queue
	//////////////////////////////////////////////////

	status_cmd_queue u_queue (
		.clk_status    (clk_status),
		.arst          (arst),
		.cmd_valid     (cmd_valid),
		.cmd_write     (cmd_write),
		.cmd_addr      (cmd_addr),
		.cmd_writedata (cmd_writedata),
		.reco_wait     (reco_wait),
		.cmd_credit    (cmd_credit),
		.st_read       (st_read),
		.st_write      (st_write),
		.st_addr       (st_addr),
		.st_writedata  (st_writedata)
	);

	//////////////////////////////////////////////////
	// clients
	//////////////////////////////////////////////////

	optics_control u_optics (
		.clk_status     (clk_status),
		.arst           (arst),
		.st_read        (st_read),
		.st_write       (st_write),
		.st_addr        (st_addr),
		.st_writedata   (st_writedata),
		.readdata       (cfp_readdata),
		.readdata_valid (cfp_readdata_valid),
		.cfp_mod_lopwr  (cfp_mod_lopwr),
		.cfp_mod_rst    (cfp_mod_rst),
		.cfp_tx_dis     (cfp_tx_dis),
		.cfp_prg_cntl   (cfp_prg_cntl),
		.cfp_glb_alrm   (cfp_glb_alrm),
		.cfp_mod_abs    (cfp_mod_abs),
		.cfp_rx_los     (cfp_rx_los),
		.cfp_prg_alrm   (cfp_prg_alrm)
	);

	reco_window u_reco (
		.clk_status     (clk_status),
		.arst           (arst),
		.st_read        (st_read),
		.st_write       (st_write),
		.st_addr        (st_addr),
		.st_writedata   (st_writedata),
		.readdata       (reco_readdata),
		.readdata_valid (reco_readdata_valid),
		.reco_wait      (reco_wait)
	);

	// merge, optics is client 0
	status_read_combine #(
		.NUM_CLIENTS (2)
	) u_combine (
		.clk_status   (clk_status),
		.arst         (arst),
		.client_valid ({reco_readdata_valid, cfp_readdata_valid}),
		.client_data  ({reco_readdata, cfp_readdata}),
		.rsp_valid    (rsp_valid),
		.rsp_data     (rsp_data)
	);

endmodule

/* sim/status_subsystem_props.sv */
//////////////////////////////////////////////////
// bus checks bound into the queue and read combiner
// inputs a binding has no use for are tied low
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module status_subsystem_props #(
	parameter int CNT_W = $clog2(`STATUS_CMD_DEPTH + 1), // same as queue count
	parameter int NUM_V = 2
) (
	input logic             clk_status,
	input logic             arst,
	input logic             reco_wait,
	input logic             st_strobe,
	input logic [CNT_W-1:0] count,
	input logic [NUM_V-1:0] client_valid
);

	// stage takes nothing during the reconfig wait
	a_no_pop_in_wait: assert property (
		@(posedge clk_status) disable iff (arst) reco_wait |-> !st_strobe
	) else $error("a command entered the stage while reco_wait was high");

	// clients never answer together
	a_valid_onehot: assert property (
		@(posedge clk_status) disable iff (arst) $onehot0(client_valid)
	) else $error("more than one client read valid in a cycle");

	a_count_bound: assert property (
		@(posedge clk_status) disable iff (arst) count <= CNT_W'(`STATUS_CMD_DEPTH)
	) else $error("command queue count above its depth");

endmodule

// the queue has no client valids
bind status_cmd_queue status_subsystem_props #(
	.NUM_V (1)
) u_queue_props (
	.clk_status   (clk_status),
	.arst         (arst),
	.reco_wait    (reco_wait),
	.st_strobe    (st_read || st_write),
	.count        (count),
	.client_valid (1'b0)
);

bind status_read_combine status_subsystem_props u_combine_props (
	.clk_status   (clk_status),
	.arst         (arst),
	.reco_wait    (1'b0),
	.st_strobe    (1'b0),
	.count        ('0),
	.client_valid (client_valid)
);

/* sim/status_subsystem_tb.sv */
//////////////////////////////////////////////////
// random host for the status bus with 400 commands
// alarm inputs only change while the bus is idle
// reco words are always written before a read
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "status_consts.svh"

module status_subsystem_tb;
	import status_bus_pkg::*;

	localparam int DEPTH    = `STATUS_CMD_DEPTH;
	localparam int NUM_CMDS = 400;
	localparam int TIMEOUT  = 200; // cycles allowed per wait

	logic                      clk_status;
	logic                      arst;
	logic                      cmd_valid;
	logic                      cmd_write;
	status_addr_t              cmd_addr;
	logic [`STATUS_DATA_W-1:0] cmd_writedata;
	logic                      cmd_credit;
	logic                      rsp_valid;
	logic [`STATUS_DATA_W-1:0] rsp_data;
	logic                      cfp_mod_lopwr;
	logic                      cfp_mod_rst;
	logic                      cfp_tx_dis;
	logic [3:1]                cfp_prg_cntl;
	logic                      cfp_glb_alrm;
	logic                      cfp_mod_abs;
	logic                      cfp_rx_los;
	logic [3:1]                cfp_prg_alrm;

	integer      seed;
	int          spent;            // credits used by the main process
	int          returned;         // credits returned as seen by the monitor
	int          sent;
	logic [31:0] reco_m [128];     // model register file
	logic        reco_valid [128]; // offset written at least once
	logic [5:0]  ctrl_m;
	logic [5:0]  sticky_m;
	logic [5:0]  pins_m;           // levels on the alarm inputs

	// expected read responses in command order
	logic [31:0] exp_data [512];
	string       exp_name [512];
	int          exp_wr;
	int          exp_rd;

	always #20 clk_status = ~clk_status; // 40 ns period

	status_subsystem DUT (
		.clk_status    (clk_status),
		.arst          (arst),
		.cmd_valid     (cmd_valid),
		.cmd_write     (cmd_write),
		.cmd_addr      (cmd_addr),
		.cmd_writedata (cmd_writedata),
		.cmd_credit    (cmd_credit),
		.rsp_valid     (rsp_valid),
		.rsp_data      (rsp_data),
		.cfp_mod_lopwr (cfp_mod_lopwr),
		.cfp_mod_rst   (cfp_mod_rst),
		.cfp_tx_dis    (cfp_tx_dis),
		.cfp_prg_cntl  (cfp_prg_cntl),
		.cfp_glb_alrm  (cfp_glb_alrm),
		.cfp_mod_abs   (cfp_mod_abs),
		.cfp_rx_los    (cfp_rx_los),
		.cfp_prg_alrm  (cfp_prg_alrm)
	);

	function automatic int host_credits();
		return DEPTH - spent + returned;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else report_failure($sformatf("Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
	endtask

	task automatic expect_read(input logic [31:0] data, input string name);
		exp_data[exp_wr] = data;
		exp_name[exp_wr] = name;
		exp_wr++;
	endtask

	//////////////////////////////////////////////////
	// monitor samples on the falling edge
	//////////////////////////////////////////////////

	always @(negedge clk_status) begin
		if (!arst) begin
			if (cmd_credit) begin
				returned++;
				assert (host_credits() <= DEPTH)
				else report_failure("host credit count went above the queue depth");
			end
			if (rsp_valid) begin
				assert (exp_rd < exp_wr)
				else report_failure("read response arrived with no read outstanding");
				check_value(exp_name[exp_rd], exp_data[exp_rd], rsp_data);
				exp_rd++;
			end
		end
	end

	//////////////////////////////////////////////////
	// host side
	//////////////////////////////////////////////////

	task automatic idle_cycle();
		@(posedge clk_status);
		cmd_valid <= 1'b0;
	endtask

	task automatic issue_cmd(input logic wr, input status_addr_t addr, input logic [31:0] data);
		int waited;
		waited = 0;
		@(posedge clk_status);
		while (host_credits() == 0) begin
			cmd_valid <= 1'b0; // hold off without a credit
			waited++;
			assert (waited < TIMEOUT)
			else report_failure("timed out waiting for a command credit");
			@(posedge clk_status);
		end
		cmd_valid     <= 1'b1;
		cmd_write     <= wr;
		cmd_addr      <= addr;
		cmd_writedata <= data;
		spent++; // one credit per valid cycle
	endtask

	// new sparse alarm levels so clears can stick
	task automatic set_alarm_levels();
		logic [31:0] r;
		r = $random(seed);
		@(posedge clk_status);
		cmd_valid <= 1'b0;
		{cfp_prg_alrm, cfp_rx_los, cfp_mod_abs, cfp_glb_alrm} <= r[5:0] & r[11:6];
		pins_m   = r[5:0] & r[11:6];
		sticky_m = sticky_m | pins_m; // latched on the next edge
	endtask

	task automatic random_cmd();
		logic [31:0]  r;
		logic [31:0]  data;
		status_addr_t a;
		logic         wr;
		r    = $random(seed);
		data = $random(seed);
		wr   = r[4];
		if (r[3:0] < 4'd8) begin
			a.win.window = `RECO_WINDOW;
			a.win.offset = r[11:5];
			if (!reco_valid[r[11:5]])
				wr = 1'b1; // file has no reset
			if (wr) begin
				reco_m[r[11:5]]     = data;
				reco_valid[r[11:5]] = 1'b1;
			end else begin
				expect_read(reco_m[r[11:5]], "reco window read");
			end
		end else if (r[3:0] < 4'd14) begin
			a.flat.page   = `OPTICS_PAGE;
			a.flat.offset = r[15:8] % 8'd3;
			case (a.flat.offset)
				`OPTICS_REG_CTRL: begin
					if (wr)
						ctrl_m = data[5:0];
					else
						expect_read({26'd0, ctrl_m}, "ctrl readback");
				end
				`OPTICS_REG_ALARM: begin
					if (wr)
						sticky_m = (sticky_m & ~data[5:0]) | pins_m; // set wins
					else
						expect_read({26'd0, sticky_m}, "alarm read");
				end
				default: begin
					if (!wr)
						expect_read({26'd0, pins_m}, "pins read"); // writes here drop
				end
			endcase
		end else begin
			wr = 1'b1; // unmapped pages take writes only
			if (r[5])
				a.word = 16'h0680 | {9'd0, r[12:6]}; // upper half of page 6
			else
				a.word = {4'h1, r[15:12], r[23:16]}; // pages 0x10-0x1f
		end
		issue_cmd(wr, a, data);
		if (r[31:30] == 2'b00)
			idle_cycle();
	endtask

	task automatic wait_bus_idle();
		int waited;
		waited = 0;
		while (host_credits() != DEPTH || exp_rd != exp_wr) begin
			@(posedge clk_status);
			waited++;
			assert (waited < TIMEOUT)
			else report_failure("timed out waiting for credits and responses to return");
		end
		// last reco write lands RECO_WAIT_CYCLES + 2 after its pop
		repeat (`RECO_WAIT_CYCLES + 2) @(posedge clk_status);
	endtask

	task automatic check_idle_state();
		check_value("cfp control outputs", {26'd0, ctrl_m},
			{26'd0, cfp_prg_cntl, cfp_tx_dis, cfp_mod_rst, cfp_mod_lopwr});
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int          i;
		int          burst;
		logic [31:0] r;
		seed          = 56;
		clk_status    = 1'b0;
		arst          = 1'b1;
		cmd_valid     = 1'b0;
		cmd_write     = 1'b0;
		cmd_addr      = '0;
		cmd_writedata = '0;
		cfp_glb_alrm  = 1'b0;
		cfp_mod_abs   = 1'b0;
		cfp_rx_los    = 1'b0;
		cfp_prg_alrm  = '0;
		spent         = 0;
		returned      = 0;
		sent          = 0;
		exp_wr        = 0;
		exp_rd        = 0;
		ctrl_m        = '0;
		sticky_m      = '0;
		pins_m        = '0;
		for (int k = 0; k < 128; k++)
			reco_valid[k] = 1'b0;

		repeat (2) @(posedge clk_status); // reset over two edges
		arst <= 1'b0;
		check_value("cfp_mod_rst after reset", 32'd0, {31'd0, cfp_mod_rst});
		check_value("outputs after reset", 32'd0,
			{24'd0, cmd_credit, rsp_valid, cfp_mod_lopwr, cfp_mod_rst, cfp_tx_dis, cfp_prg_cntl});

		while (sent < NUM_CMDS) begin
			set_alarm_levels();
			r     = $random(seed);
			burst = 1 + int'(r[3:0]); // longer than depth at times
			for (i = 0; i < burst && sent < NUM_CMDS; i++) begin
				random_cmd();
				sent++;
			end
			idle_cycle();
			wait_bus_idle();
			check_idle_state();
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
hdl/status_bus_pkg.sv
hdl/status_cmd_queue.sv
hdl/optics_control.sv
hdl/reco_window.sv
hdl/status_read_combine.sv
hdl/status_subsystem.sv
sim/status_subsystem_props.sv
sim/status_subsystem_tb.sv

/* Makefile */
# Verilator flow for the status bus testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= status_subsystem_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
